// File: test/eth_vectors.txt
// port op(0 write,1 read) sel(0 index,1 data) data expected_read
0 0 0 00000001 00000000
1 0 0 00000004 00000000
0 0 1 FFFF1234 00000000
1 0 1 0000A5A5 00000000
0 0 0 00000001 00000000
1 0 0 00000005 00000000
0 1 1 00000000 00001234
1 0 1 00005A5A 00000000
0 0 0 00000002 00000000
1 0 0 00000004 00000000
0 0 1 0000BEEF 00000000
1 1 1 00000000 0000A5A5
0 0 0 00000002 00000000
1 0 0 00000005 00000000
0 1 0 00000000 00000002
1 1 1 00000000 00005A5A
0 0 0 0000000F 00000000
1 0 0 00000004 00000000
0 1 1 00000000 00000A46
1 0 1 FFFF00C3 00000000
0 0 0 00000002 00000000
1 0 0 00000004 00000000
0 1 1 00000000 0000BEEF
1 1 1 00000000 000000C3

// File: sources.f
logic/eth_pkg.sv
logic/axil_port.sv
logic/bus_arbiter.sv
logic/chip_access.sv
logic/eth_if_top.sv
test/chip_model.sv
test/eth_if_tb.sv

// File: Makefile
# Verilator build and run of the Ethernet interface testbench.
SIM := obj_dir/Veth_if_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module eth_if_tb -f sources.f -o Veth_if_tb

run: compile
	$(SIM) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/eth_if_tb.sv
`timescale 1ns/1ps

module eth_if_tb;

    import eth_pkg::*;

    localparam int strobe_cycles  = 2;
    localparam int recover_cycles = 4;
    localparam int max_vectors    = 64;

    // Phases of each port master.
    localparam int ph_idle     = 0;
    localparam int ph_addr     = 1;
    localparam int ph_accepted = 2;
    localparam int ph_resp     = 3;
    localparam int ph_ack      = 4;
    localparam int ph_end      = 5;

    // Every response on both ports is OKAY.
    localparam axil_resp_t resp_okay = 2'b00;

    logic       clk;
    logic       rst;
    logic [1:0] awvalid;
    logic [1:0] awready;
    logic [1:0] wvalid;
    logic [1:0] wready;
    logic [1:0] bvalid;
    logic [1:0] bready;
    logic [1:0] arvalid;
    logic [1:0] arready;
    logic [1:0] rvalid;
    logic [1:0] rready;
    axil_addr_t awaddr [2];
    axil_addr_t araddr [2];
    bus_word_t  wdata [2];
    bus_word_t  rdata [2];
    axil_resp_t bresp [2];
    axil_resp_t rresp [2];
    logic       cs_n;
    logic       ior_n;
    logic       iow_n;
    logic       chip_cmd;
    logic       sd_oe;
    chip_word_t sd_out;
    chip_word_t sd_in;

    // Five words per vector: port, op, sel, data, expected read value.
    bus_word_t  vec_mem [5*max_vectors];
    int         plist [2][max_vectors];
    int         pcount [2];
    int         pos [2];
    int         phase [2];
    int         stall [2];
    int         n_vectors;
    int         cycle_limit;
    int         cycles;
    int         strobe_run;
    int         cs_run;
    int         accesses;
    int         checks;
    int         value_errors;
    int         other_errors;
    logic [7:0] lfsr;

    eth_if_top #(
        .strobe_cycles(strobe_cycles),
        .recover_cycles(recover_cycles)
    ) uut (
        .clk(clk), .rst(rst),
        .s0_awvalid(awvalid[0]), .s0_awready(awready[0]), .s0_awaddr(awaddr[0]),
        .s0_wvalid(wvalid[0]), .s0_wready(wready[0]), .s0_wdata(wdata[0]),
        .s0_bvalid(bvalid[0]), .s0_bready(bready[0]), .s0_bresp(bresp[0]),
        .s0_arvalid(arvalid[0]), .s0_arready(arready[0]), .s0_araddr(araddr[0]),
        .s0_rvalid(rvalid[0]), .s0_rready(rready[0]), .s0_rdata(rdata[0]),
        .s0_rresp(rresp[0]),
        .s1_awvalid(awvalid[1]), .s1_awready(awready[1]), .s1_awaddr(awaddr[1]),
        .s1_wvalid(wvalid[1]), .s1_wready(wready[1]), .s1_wdata(wdata[1]),
        .s1_bvalid(bvalid[1]), .s1_bready(bready[1]), .s1_bresp(bresp[1]),
        .s1_arvalid(arvalid[1]), .s1_arready(arready[1]), .s1_araddr(araddr[1]),
        .s1_rvalid(rvalid[1]), .s1_rready(rready[1]), .s1_rdata(rdata[1]),
        .s1_rresp(rresp[1]),
        .chip_cs_n(cs_n), .chip_ior_n(ior_n), .chip_iow_n(iow_n),
        .chip_cmd(chip_cmd), .chip_sd_out(sd_out), .chip_sd_oe(sd_oe),
        .chip_sd_in(sd_in)
    );

    chip_model chip (
        .clk(clk), .rst(rst),
        .cs_n(cs_n), .ior_n(ior_n), .iow_n(iow_n), .cmd(chip_cmd),
        .data_in(sd_out), .data_out(sd_in)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_rdata(input string name, input bus_word_t got, input bus_word_t exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("error: time %0t signal %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("error: time %0t signal %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_strobe(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            value_errors++;
            $display("error: time %0t signal %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("error: time %0t signal %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("failure at %0t: %s", $time, what);
    endtask

    // Fibonacci LFSR, taps 8, 6, 5, 4.
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic draw_stall(output int len);
        len = 0;
        for (int b = 0; b < 3; b++) begin
            lfsr = lfsr_step(lfsr);
            len  = (len << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic load_vectors();
        int p;
        for (int i = 0; i < 5*max_vectors; i++) begin
            vec_mem[i] = '1;
        end
        $readmemh("test/eth_vectors.txt", vec_mem);
        n_vectors = 0;
        while (n_vectors < max_vectors && vec_mem[5*n_vectors] != '1) begin
            n_vectors++;
        end
        for (int i = 0; i < 2; i++) begin
            pcount[i] = 0;
            pos[i]    = 0;
            phase[i]  = ph_idle;
        end
        for (int i = 0; i < n_vectors; i++) begin
            p = int'(vec_mem[5*i][0]);
            plist[p][pcount[p]] = i;
            pcount[p]++;
        end
        if (n_vectors == 0) begin
            report_failure("no vectors were read from test/eth_vectors.txt");
        end
    endtask

    // Strobe pins are registered, so the falling edge sees settled levels.
    task automatic measure_strobe();
        if (!ior_n || !iow_n) begin
            strobe_run++;
            if (!iow_n && !sd_oe) begin
                report_failure("write strobe active while the data pins are not driven");
            end
            if (!ior_n && sd_oe) begin
                report_failure("read strobe active while the data pins are driven");
            end
        end else if (strobe_run > 0) begin
            check_strobe("strobe_low_cycles", strobe_run, strobe_cycles);
            strobe_run = 0;
            accesses++;
        end
        if (!cs_n) begin
            cs_run++;
        end else if (cs_run > 0) begin
            check_strobe("cs_n_low_cycles", cs_run, strobe_cycles + recover_cycles);
            cs_run = 0;
        end
    endtask

    // Ready seen now means the handshake happens at the next rising edge.
    task automatic sample_ready(input int p);
        int   idx;
        logic is_read;
        if (phase[p] == ph_addr) begin
            idx     = plist[p][pos[p]];
            is_read = vec_mem[5*idx+1][0];
            if (is_read ? arready[p] : (awready[p] && wready[p])) begin
                phase[p] = ph_accepted;
            end
        end
    endtask

    task automatic step_port(input int p);
        int   idx;
        logic is_read;
        idx = 0;
        if (pos[p] < pcount[p]) begin
            idx = plist[p][pos[p]];
        end
        is_read = vec_mem[5*idx+1][0];
        case (phase[p])
            ph_idle: begin
                if (bvalid[p] || rvalid[p]) begin
                    report_failure($sformatf("port %0d responded with no transaction open", p));
                end
                if (pos[p] >= pcount[p]) begin
                    phase[p] = ph_end;
                end else if (is_read) begin
                    arvalid[p] = 1'b1;
                    araddr[p]  = {5'b00000, vec_mem[5*idx+2][0], 2'b00};
                    phase[p]   = ph_addr;
                end else begin
                    awvalid[p] = 1'b1;
                    wvalid[p]  = 1'b1;
                    awaddr[p]  = {5'b00000, vec_mem[5*idx+2][0], 2'b00};
                    wdata[p]   = vec_mem[5*idx+3];
                    phase[p]   = ph_addr;
                end
            end
            ph_accepted: begin
                arvalid[p] = 1'b0;
                awvalid[p] = 1'b0;
                wvalid[p]  = 1'b0;
                draw_stall(stall[p]);
                phase[p] = ph_resp;
            end
            ph_resp: begin
                if (is_read ? bvalid[p] : rvalid[p]) begin
                    report_failure($sformatf("port %0d returned the wrong response type", p));
                end
                if (is_read ? rvalid[p] : bvalid[p]) begin
                    if (stall[p] > 0) begin
                        stall[p]--;
                    end else if (is_read) begin
                        rready[p] = 1'b1;
                        check_rdata($sformatf("s%0d_rdata", p), rdata[p], vec_mem[5*idx+4]);
                        check_resp($sformatf("s%0d_rresp", p), rresp[p], resp_okay);
                        phase[p] = ph_ack;
                    end else begin
                        bready[p] = 1'b1;
                        check_resp($sformatf("s%0d_bresp", p), bresp[p], resp_okay);
                        phase[p] = ph_ack;
                    end
                end
            end
            ph_ack: begin
                bready[p] = 1'b0;
                rready[p] = 1'b0;
                pos[p]++;
                phase[p] = ph_idle;
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        rst     = 1'b1;
        awvalid = '0;
        wvalid  = '0;
        bready  = '0;
        arvalid = '0;
        rready  = '0;
        for (int p = 0; p < 2; p++) begin
            awaddr[p] = '0;
            araddr[p] = '0;
            wdata[p]  = '0;
            stall[p]  = 0;
        end
        lfsr         = 8'd55;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        strobe_run   = 0;
        cs_run       = 0;
        accesses     = 0;
        cycles       = 0;
        load_vectors();
        cycle_limit = 40 * n_vectors + 200;

        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_level("chip_cs_n", cs_n, 1'b1);
        check_level("chip_ior_n", ior_n, 1'b1);
        check_level("chip_iow_n", iow_n, 1'b1);
        check_level("chip_sd_oe", sd_oe, 1'b0);
        check_level("bvalid", |bvalid, 1'b0);
        check_level("rvalid", |rvalid, 1'b0);

        while ((phase[0] != ph_end || phase[1] != ph_end) && cycles < cycle_limit) begin
            @(negedge clk);
            cycles++;
            measure_strobe();
            step_port(0);
            step_port(1);
            #1;
            sample_ready(0);
            sample_ready(1);
        end

        if (phase[0] != ph_end || phase[1] != ph_end) begin
            report_failure($sformatf("timeout, ports still busy after %0d cycles", cycles));
        end else begin
            check_strobe("chip_accesses", accesses, n_vectors);
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: test/chip_model.sv
`timescale 1ns/1ps

module chip_model (
    input  logic                clk,
    input  logic                rst,
    input  logic                cs_n,
    input  logic                ior_n,
    input  logic                iow_n,
    input  logic                cmd,
    input  eth_pkg::chip_word_t data_in,
    output eth_pkg::chip_word_t data_out
);

    import eth_pkg::*;

    localparam chip_word_t id_value = 16'h0A46;

    chip_word_t index;
    chip_word_t regs [16];
    chip_word_t selected;

    // Register 15 always reads as the chip ID.
    assign selected = (index[3:0] == 4'hf) ? id_value : regs[index[3:0]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            index <= '0;
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (!cs_n && !iow_n) begin
            if (!cmd) begin
                index <= data_in;
            end else begin
                regs[index[3:0]] <= data_in;
            end
        end
    end

    // The index port reads back the index itself.
    always_comb begin
        data_out = '0;
        if (!cs_n && !ior_n) begin
            data_out = cmd ? selected : index;
        end
    end

endmodule

// File: logic/eth_if_top.sv
`timescale 1ns/1ps

module eth_if_top #(
    parameter int strobe_cycles  = 2,
    parameter int recover_cycles = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                s0_awvalid,
    output logic                s0_awready,
    input  eth_pkg::axil_addr_t s0_awaddr,
    input  logic                s0_wvalid,
    output logic                s0_wready,
    input  eth_pkg::bus_word_t  s0_wdata,
    output logic                s0_bvalid,
    input  logic                s0_bready,
    output eth_pkg::axil_resp_t s0_bresp,
    input  logic                s0_arvalid,
    output logic                s0_arready,
    input  eth_pkg::axil_addr_t s0_araddr,
    output logic                s0_rvalid,
    input  logic                s0_rready,
    output eth_pkg::bus_word_t  s0_rdata,
    output eth_pkg::axil_resp_t s0_rresp,
    input  logic                s1_awvalid,
    output logic                s1_awready,
    input  eth_pkg::axil_addr_t s1_awaddr,
    input  logic                s1_wvalid,
    output logic                s1_wready,
    input  eth_pkg::bus_word_t  s1_wdata,
    output logic                s1_bvalid,
    input  logic                s1_bready,
    output eth_pkg::axil_resp_t s1_bresp,
    input  logic                s1_arvalid,
    output logic                s1_arready,
    input  eth_pkg::axil_addr_t s1_araddr,
    output logic                s1_rvalid,
    input  logic                s1_rready,
    output eth_pkg::bus_word_t  s1_rdata,
    output eth_pkg::axil_resp_t s1_rresp,
    output logic                chip_cs_n,
    output logic                chip_ior_n,
    output logic                chip_iow_n,
    output logic                chip_cmd,
    output eth_pkg::chip_word_t chip_sd_out,
    output logic                chip_sd_oe,
    input  eth_pkg::chip_word_t chip_sd_in
);

    import eth_pkg::*;

    logic       p0_req;
    logic       p0_wr;
    logic       p0_cmd;
    logic       p0_done;
    chip_word_t p0_wdata;
    chip_word_t p0_rdata;
    logic       p1_req;
    logic       p1_wr;
    logic       p1_cmd;
    logic       p1_done;
    chip_word_t p1_wdata;
    chip_word_t p1_rdata;
    logic       acc_start;
    logic       acc_wr;
    logic       acc_cmd;
    logic       acc_done;
    chip_word_t acc_wdata;
    chip_word_t acc_rdata;

    axil_port port0 (
        .clk(clk), .rst(rst),
        .awvalid(s0_awvalid), .awready(s0_awready), .awaddr(s0_awaddr),
        .wvalid(s0_wvalid), .wready(s0_wready), .wdata(s0_wdata),
        .bvalid(s0_bvalid), .bready(s0_bready), .bresp(s0_bresp),
        .arvalid(s0_arvalid), .arready(s0_arready), .araddr(s0_araddr),
        .rvalid(s0_rvalid), .rready(s0_rready), .rdata(s0_rdata), .rresp(s0_rresp),
        .req(p0_req), .wr(p0_wr), .cmd(p0_cmd), .req_wdata(p0_wdata),
        .done(p0_done), .done_rdata(p0_rdata)
    );

    axil_port port1 (
        .clk(clk), .rst(rst),
        .awvalid(s1_awvalid), .awready(s1_awready), .awaddr(s1_awaddr),
        .wvalid(s1_wvalid), .wready(s1_wready), .wdata(s1_wdata),
        .bvalid(s1_bvalid), .bready(s1_bready), .bresp(s1_bresp),
        .arvalid(s1_arvalid), .arready(s1_arready), .araddr(s1_araddr),
        .rvalid(s1_rvalid), .rready(s1_rready), .rdata(s1_rdata), .rresp(s1_rresp),
        .req(p1_req), .wr(p1_wr), .cmd(p1_cmd), .req_wdata(p1_wdata),
        .done(p1_done), .done_rdata(p1_rdata)
    );

    bus_arbiter arbiter (
        .clk(clk), .rst(rst),
        .req0(p0_req), .wr0(p0_wr), .cmd0(p0_cmd), .wdata0(p0_wdata),
        .req1(p1_req), .wr1(p1_wr), .cmd1(p1_cmd), .wdata1(p1_wdata),
        .done0(p0_done), .done1(p1_done), .rdata0(p0_rdata), .rdata1(p1_rdata),
        .start(acc_start), .wr(acc_wr), .cmd(acc_cmd), .wdata(acc_wdata),
        .acc_done(acc_done), .acc_rdata(acc_rdata)
    );

    chip_access #(
        .strobe_cycles(strobe_cycles),
        .recover_cycles(recover_cycles)
    ) sequencer (
        .clk(clk), .rst(rst),
        .start(acc_start), .wr(acc_wr), .cmd(acc_cmd), .wdata(acc_wdata),
        .done(acc_done), .rdata(acc_rdata),
        .cs_n(chip_cs_n), .ior_n(chip_ior_n), .iow_n(chip_iow_n),
        .chip_cmd(chip_cmd), .sd_out(chip_sd_out), .sd_oe(chip_sd_oe),
        .sd_in(chip_sd_in)
    );

endmodule

// File: logic/chip_access.sv
`timescale 1ns/1ps

module chip_access #(
    parameter int strobe_cycles  = 2,
    parameter int recover_cycles = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                wr,
    input  logic                cmd,
    input  eth_pkg::chip_word_t wdata,
    output logic                done,
    output eth_pkg::chip_word_t rdata,
    output logic                cs_n,
    output logic                ior_n,
    output logic                iow_n,
    output logic                chip_cmd,
    output eth_pkg::chip_word_t sd_out,
    output logic                sd_oe,
    input  eth_pkg::chip_word_t sd_in
);

    import eth_pkg::*;

    localparam int max_cycles = (strobe_cycles > recover_cycles) ? strobe_cycles
                                                                 : recover_cycles;
    localparam int cnt_w = (max_cycles > 1) ? $clog2(max_cycles) : 1;
    localparam logic [cnt_w-1:0] strobe_last  = cnt_w'(strobe_cycles - 1);
    localparam logic [cnt_w-1:0] recover_last = cnt_w'(recover_cycles - 1);

    access_state_t    state;
    logic [cnt_w-1:0] count;
    logic             wr_q;
    logic             launch;

    assign launch = (state == ACC_IDLE) && start;

    // Strobes are registered so the chip pins never glitch.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ACC_IDLE;
            count <= '0;
            cs_n  <= 1'b1;
            ior_n <= 1'b1;
            iow_n <= 1'b1;
            sd_oe <= 1'b0;
        end else begin
            case (state)
                ACC_IDLE: begin
                    count <= '0;
                    if (start) begin
                        state <= ACC_STROBE;
                        cs_n  <= 1'b0;
                        ior_n <= wr;
                        iow_n <= !wr;
                        sd_oe <= wr;
                    end
                end
                ACC_STROBE: begin
                    if (count == strobe_last) begin
                        count <= '0;
                        ior_n <= 1'b1;
                        iow_n <= 1'b1;
                        state <= ACC_RECOVER;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                ACC_RECOVER: begin
                    // Chip select stays low through recovery.
                    if (count == recover_last) begin
                        count <= '0;
                        cs_n  <= 1'b1;
                        sd_oe <= 1'b0;
                        state <= ACC_DONE;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                ACC_DONE: begin
                    state <= ACC_IDLE;
                end
                default: begin
                    state <= ACC_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            chip_cmd <= cmd;
            sd_out   <= wdata;
            wr_q     <= wr;
        end
        // Read data is taken in the last strobe cycle.
        if (state == ACC_STROBE && count == strobe_last && !wr_q) begin
            rdata <= sd_in;
        end
    end

    assign done = (state == ACC_DONE);

endmodule

// File: logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                req0,
    input  logic                wr0,
    input  logic                cmd0,
    input  eth_pkg::chip_word_t wdata0,
    input  logic                req1,
    input  logic                wr1,
    input  logic                cmd1,
    input  eth_pkg::chip_word_t wdata1,
    output logic                done0,
    output logic                done1,
    output eth_pkg::chip_word_t rdata0,
    output eth_pkg::chip_word_t rdata1,
    output logic                start,
    output logic                wr,
    output logic                cmd,
    output eth_pkg::chip_word_t wdata,
    input  logic                acc_done,
    input  eth_pkg::chip_word_t acc_rdata
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_GRANT,
        ARB_BUSY
    } arb_state_t;

    arb_state_t state;
    logic       owner;
    logic       prio;
    logic       locked;
    logic       lock_port;
    logic       pick_valid;
    logic       pick;
    logic       finish;

    // While locked only the port that wrote the index may be picked.
    always_comb begin
        pick_valid = 1'b0;
        pick       = prio;
        if (locked) begin
            pick       = lock_port;
            pick_valid = lock_port ? req1 : req0;
        end else if (req0 && req1) begin
            pick_valid = 1'b1;
        end else if (req0 || req1) begin
            pick       = req1;
            pick_valid = 1'b1;
        end
    end

    assign finish = (state == ARB_BUSY) && acc_done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ARB_IDLE;
            owner     <= 1'b0;
            prio      <= 1'b0;
            locked    <= 1'b0;
            lock_port <= 1'b0;
            start     <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (pick_valid) begin
                        owner <= pick;
                        prio  <= ~pick;
                        state <= ARB_GRANT;
                    end
                end
                ARB_GRANT: begin
                    start <= 1'b1;
                    state <= ARB_BUSY;
                end
                ARB_BUSY: begin
                    if (acc_done) begin
                        // An index write holds the grant for the data access.
                        locked    <= wr && !cmd;
                        lock_port <= owner;
                        state     <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    assign wr    = owner ? wr1 : wr0;
    assign cmd   = owner ? cmd1 : cmd0;
    assign wdata = owner ? wdata1 : wdata0;

    assign done0  = finish && !owner;
    assign done1  = finish && owner;
    assign rdata0 = owner ? '0 : acc_rdata;
    assign rdata1 = owner ? acc_rdata : '0;

endmodule

// File: logic/axil_port.sv
`timescale 1ns/1ps

module axil_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                awvalid,
    output logic                awready,
    input  eth_pkg::axil_addr_t awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  eth_pkg::bus_word_t  wdata,
    output logic                bvalid,
    input  logic                bready,
    output eth_pkg::axil_resp_t bresp,
    input  logic                arvalid,
    output logic                arready,
    input  eth_pkg::axil_addr_t araddr,
    output logic                rvalid,
    input  logic                rready,
    output eth_pkg::bus_word_t  rdata,
    output eth_pkg::axil_resp_t rresp,
    output logic                req,
    output logic                wr,
    output logic                cmd,
    output eth_pkg::chip_word_t req_wdata,
    input  logic                done,
    input  eth_pkg::chip_word_t done_rdata
);

    import eth_pkg::*;

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_REQ,
        PORT_RESP
    } port_state_t;

    port_state_t state;
    logic        take_write;
    logic        take_read;
    logic        resp_taken;

    // A write wins when both channels are offered in the same cycle.
    assign take_write = (state == PORT_IDLE) && awvalid && wvalid;
    assign take_read  = (state == PORT_IDLE) && arvalid && !take_write;

    assign awready = take_write;
    assign wready  = take_write;
    assign arready = take_read;

    assign req    = (state == PORT_REQ);
    assign bvalid = (state == PORT_RESP) && wr;
    assign rvalid = (state == PORT_RESP) && !wr;
    assign bresp  = axil_resp_okay;
    assign rresp  = axil_resp_okay;

    assign resp_taken = (bvalid && bready) || (rvalid && rready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= PORT_IDLE;
            wr    <= 1'b0;
        end else begin
            case (state)
                PORT_IDLE: begin
                    if (take_write || take_read) begin
                        state <= PORT_REQ;
                    end
                end
                PORT_REQ: begin
                    if (done) begin
                        state <= PORT_RESP;
                    end
                end
                PORT_RESP: begin
                    if (resp_taken) begin
                        state <= PORT_IDLE;
                    end
                end
                default: begin
                    state <= PORT_IDLE;
                end
            endcase

            if (take_write) begin
                wr <= 1'b1;
            end else if (take_read) begin
                wr <= 1'b0;
            end
        end
    end

    // Only the low half of a write reaches the chip.
    always_ff @(posedge clk) begin
        if (take_write) begin
            cmd       <= awaddr[cmd_addr_bit];
            req_wdata <= wdata[15:0];
        end else if (take_read) begin
            cmd <= araddr[cmd_addr_bit];
        end
        if (done) begin
            rdata <= {16'h0000, done_rdata};
        end
    end

endmodule

// File: logic/eth_pkg.sv
package eth_pkg;

    // One AXI4-Lite data word.
    typedef logic [31:0] bus_word_t;

    // One value on the chip data bus.
    typedef logic [15:0] chip_word_t;

    // Byte address on the AXI4-Lite ports.
    typedef logic [7:0] axil_addr_t;

    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t axil_resp_okay = 2'b00;

    // Address bit that picks the data port over the index port.
    localparam int cmd_addr_bit = 2;

    // Chip access sequencer states.
    typedef enum logic [1:0] {
        ACC_IDLE,
        ACC_STROBE,
        ACC_RECOVER,
        ACC_DONE
    } access_state_t;

endpackage
